// ==== hw/cnn_conv_macros.svh ====
// compile-time sizes for the convolution core
// include wherever a width or a channel count is needed

`ifndef CNN_CONV_MACROS_SVH
`define CNN_CONV_MACROS_SVH

// ======================================================================
// kernel geometry and channel counts
// ======================================================================
`define CNN_KX      3                         // kernel width
`define CNN_KY      3                         // kernel height
`define CNN_CI      3                         // input channels
`define CNN_CO      2                         // output channels, one lane each

// ======================================================================
// datapath widths
// ======================================================================
`define CNN_W_BW    8                         // signed weight
`define CNN_I_BW    8                         // signed feature value
`define CNN_M_BW    (`CNN_W_BW + `CNN_I_BW)   // one product
// 9 products need 4 guard bits
`define CNN_AK_BW   (`CNN_M_BW + 4)
// 3 kernel sums need 2 more
`define CNN_ACI_BW  (`CNN_AK_BW + 2)
`define CNN_B_BW    16                        // signed bias
`define CNN_O_BW    16                        // unsigned output pixel

`endif

// ==== hw/cnn_conv_pkg.sv ====
// shared types for the convolution core and its testbench
// element types first, then the beat and weight bus layouts

`include "cnn_conv_macros.svh"

package cnn_conv_pkg;

    // ======================================================================
    // scalar element types
    // ======================================================================
    typedef logic signed [`CNN_I_BW-1:0]   fval_t;   // feature value
    typedef logic signed [`CNN_W_BW-1:0]   wval_t;   // weight
    typedef logic signed [`CNN_M_BW-1:0]   prod_t;   // feature x weight
    typedef logic signed [`CNN_ACI_BW-1:0] aci_t;    // sum across input channels
    typedef logic signed [`CNN_B_BW-1:0]   bias_t;
    typedef logic        [`CNN_O_BW-1:0]   pix_t;    // unsigned output value

    // ======================================================================
    // window and weight layouts
    // ======================================================================
    // index k = y*KX + x, element 0 in the low bits
    typedef fval_t [`CNN_KX*`CNN_KY-1:0] kwin_t;     // 72 bits
    typedef wval_t [`CNN_KX*`CNN_KY-1:0] kwgt_t;     // 72 bits

    // input beat, one window per input channel
    typedef struct packed {
        kwin_t [`CNN_CI-1:0] win;
    } fmap_t;

    typedef kwgt_t   [`CNN_CI-1:0] wgt_ci_t;         // weights of one output lane
    typedef wgt_ci_t [`CNN_CO-1:0] wgt_all_t;        // full static weight bus
    typedef bias_t   [`CNN_CO-1:0] bias_all_t;

    // output beat, lane 0 in the low bits
    typedef pix_t [`CNN_CO-1:0] pix_out_t;

endpackage

// ==== hw/cnn_kernel.sv ====
// one KX x KY multiply-accumulate kernel
// stage 1 registers the products, stage 2 the kernel sum; 2 cycles latency

`timescale 1ns/100ps
`include "cnn_conv_macros.svh"

module cnn_kernel (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           i_in_valid,
    input  cnn_conv_pkg::kwin_t            i_in_fmap,
    input  cnn_conv_pkg::kwgt_t            i_weight,      // static, held by system
    output logic                           o_ot_valid,
    output logic signed [`CNN_AK_BW-1:0]   o_ot_kernel_acc
);
    import cnn_conv_pkg::*;

    localparam int N_TAP = `CNN_KX * `CNN_KY;

    // ======================================================================
    // valid pipe
    // ======================================================================
    logic r_mul_valid;                       // products ready
    logic r_acc_valid;                       // kernel sum ready

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_mul_valid <= 1'b0;
            r_acc_valid <= 1'b0;
        end else begin
            r_mul_valid <= i_in_valid;
            r_acc_valid <= r_mul_valid;
        end
    end

    // ======================================================================
    // stage 1, one signed multiply per tap
    // ======================================================================
    prod_t [N_TAP-1:0] r_mul;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_mul <= '0;
        end else if (i_in_valid) begin
            for (int k = 0; k < N_TAP; k++) begin
                r_mul[k] <= $signed(i_in_fmap[k]) * $signed(i_weight[k]);
            end
        end
    end

    // ======================================================================
    // stage 2, sum the products
    // ======================================================================
    logic signed [`CNN_AK_BW-1:0] w_sum;
    logic signed [`CNN_AK_BW-1:0] r_acc;

    always_comb begin
        w_sum = '0;
        for (int k = 0; k < N_TAP; k++) begin
            w_sum = w_sum + r_mul[k];        // sign extends into guard bits
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_acc <= '0;
        end else if (r_mul_valid) begin
            r_acc <= w_sum;
        end
    end

    assign o_ot_valid      = r_acc_valid;
    assign o_ot_kernel_acc = r_acc;

endmodule

// ==== hw/cnn_acc_ci.sv ====
// sum over input channels for one output lane
// CI kernels run side by side; their sums are added and registered
// latency 3 cycles, kernel 2 plus this adder

`timescale 1ns/100ps
`include "cnn_conv_macros.svh"

module cnn_acc_ci (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            i_in_valid,
    input  cnn_conv_pkg::fmap_t             i_in_fmap,
    input  cnn_conv_pkg::wgt_ci_t           i_weight,
    output logic                            o_ot_valid,
    output logic signed [`CNN_ACI_BW-1:0]   o_ot_ci_acc
);
    import cnn_conv_pkg::*;

    // ======================================================================
    // kernels, one per input channel
    // ======================================================================
    logic [`CNN_CI-1:0]           w_k_valid;
    logic signed [`CNN_AK_BW-1:0] w_k_acc [`CNN_CI];

    for (genvar gi = 0; gi < `CNN_CI; gi++) begin : g_kernel
        kwin_t w_win;
        kwgt_t w_wgt;

        assign w_win = i_in_fmap.win[gi];    // channel gi window
        assign w_wgt = i_weight[gi];

        cnn_kernel cnn_kernel_i (
            .clk             (clk),
            .reset_n         (reset_n),
            .i_in_valid      (i_in_valid),
            .i_in_fmap       (w_win),
            .i_weight        (w_wgt),
            .o_ot_valid      (w_k_valid[gi]),
            .o_ot_kernel_acc (w_k_acc[gi])
        );
    end

    // ======================================================================
    // channel adder
    // ======================================================================
    logic  w_all_valid;
    aci_t  w_sum;
    aci_t  r_acc;
    logic  r_valid;

    assign w_all_valid = &w_k_valid;         // identical timing, AND for safety

    always_comb begin
        w_sum = '0;
        for (int c = 0; c < `CNN_CI; c++) begin
            w_sum = w_sum + w_k_acc[c];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid <= 1'b0;
            r_acc   <= '0;
        end else begin
            r_valid <= w_all_valid;
            if (w_all_valid) r_acc <= w_sum; // hold between beats
        end
    end

    assign o_ot_valid  = r_valid;
    assign o_ot_ci_acc = r_acc;

endmodule

// ==== hw/cnn_bias_relu.sv ====
// bias add, ReLU and saturation to the unsigned output width
// one register stage, valid travels with the pixel

`timescale 1ns/100ps
`include "cnn_conv_macros.svh"

module cnn_bias_relu (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            i_in_valid,
    input  logic signed [`CNN_ACI_BW-1:0]   i_ci_acc,
    input  logic signed [`CNN_B_BW-1:0]     i_bias,       // static per lane
    output logic                            o_ot_valid,
    output logic        [`CNN_O_BW-1:0]     o_ot_pix
);
    import cnn_conv_pkg::*;

    // one bit above the wider operand, sum never overflows
    localparam int S_BW = ((`CNN_ACI_BW > `CNN_B_BW) ? `CNN_ACI_BW : `CNN_B_BW) + 1;

    // largest output value, zero extended into the sum width
    localparam logic signed [S_BW-1:0] PIX_MAX =
        {{(S_BW-`CNN_O_BW){1'b0}}, {`CNN_O_BW{1'b1}}};

    logic signed [S_BW-1:0] w_sum;
    pix_t                   w_pix;
    pix_t                   r_pix;
    logic                   r_valid;

    assign w_sum = S_BW'(i_ci_acc) + S_BW'(i_bias);   // both sign extended

    // ======================================================================
    // ReLU then clip
    // ======================================================================
    always_comb begin
        if (w_sum[S_BW-1]) begin
            w_pix = '0;                      // negative
        end else if (w_sum > PIX_MAX) begin
            w_pix = '1;                      // saturate
        end else begin
            w_pix = w_sum[`CNN_O_BW-1:0];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid <= 1'b0;
            r_pix   <= '0;
        end else begin
            r_valid <= i_in_valid;
            if (i_in_valid) r_pix <= w_pix;
        end
    end

    assign o_ot_valid = r_valid;
    assign o_ot_pix   = r_pix;

endmodule

// ==== hw/cnn_core.sv ====
// convolution core top, CO output lanes in parallel
// lane = channel accumulator then bias/ReLU; 4 cycles in to out, no stall

`timescale 1ns/100ps
`include "cnn_conv_macros.svh"

module cnn_core (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    i_in_valid,
    input  cnn_conv_pkg::fmap_t     i_in_fmap,
    input  cnn_conv_pkg::wgt_all_t  i_weight,     // static weight bus
    input  cnn_conv_pkg::bias_all_t i_bias,       // static biases
    output logic                    o_ot_valid,
    output cnn_conv_pkg::pix_out_t  o_ot_pix
);
    import cnn_conv_pkg::*;

    logic [`CNN_CO-1:0] w_lane_valid;             // same timing in every lane

    // ======================================================================
    // output lanes
    // ======================================================================
    for (genvar go = 0; go < `CNN_CO; go++) begin : g_lane
        aci_t w_ci_acc;
        logic w_acc_valid;

        cnn_acc_ci cnn_acc_ci_i (
            .clk         (clk),
            .reset_n     (reset_n),
            .i_in_valid  (i_in_valid),
            .i_in_fmap   (i_in_fmap),             // full beat to every lane
            .i_weight    (i_weight[go]),
            .o_ot_valid  (w_acc_valid),
            .o_ot_ci_acc (w_ci_acc)
        );

        cnn_bias_relu cnn_bias_relu_i (
            .clk        (clk),
            .reset_n    (reset_n),
            .i_in_valid (w_acc_valid),
            .i_ci_acc   (w_ci_acc),
            .i_bias     (i_bias[go]),
            .o_ot_valid (w_lane_valid[go]),
            .o_ot_pix   (o_ot_pix[go])
        );
    end

    assign o_ot_valid = w_lane_valid[0];          // lane 0 speaks for all

endmodule

// ==== tests/tb_clock.sv ====
// clock and reset source for the testbench
// 100 ns clock, reset_n held low for the first 16 rising edges

`timescale 1ns/100ps

module tb_clock #(
    parameter int HALF_PERIOD  = 50,         // ns
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset_n
);
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;                     // release right after an edge
    end

endmodule

// ==== tests/cnn_core_chk.sv ====
// protocol checks on the core output
// bound into every cnn_core
// fixed 4 cycle latency and a quiet output valid in reset

`timescale 1ns/100ps

module cnn_core_chk (
    input logic clk,
    input logic reset_n,
    input logic i_in_valid,
    input logic o_ot_valid
);
    int fail_cnt = 0;                        // failed assertions so far

    // ======================================================================
    // timing
    // ======================================================================
    // valid is the accepted input delayed by exactly four clocks
    a_latency : assert property (@(posedge clk) disable iff (!reset_n)
        o_ot_valid == $past(i_in_valid, 4))
        else begin
            fail_cnt++;
            $error("output valid does not follow input valid by 4 cycles");
        end

    a_reset_quiet : assert property (@(posedge clk)
        !reset_n |-> !o_ot_valid)            // async reset clears every valid
        else begin
            fail_cnt++;
            $error("output valid high while reset is asserted");
        end

endmodule

bind cnn_core cnn_core_chk cnn_core_chk_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_in_valid (i_in_valid),
    .o_ot_valid (o_ot_valid)
);

// ==== tests/cnn_core_tb.sv ====
// testbench for the convolution core
// random beats against a reference model, one report line per test

`timescale 1ns/100ps
`include "cnn_conv_macros.svh"

module cnn_core_tb;
    import cnn_conv_pkg::*;

    localparam int N_TAP   = `CNN_KX * `CNN_KY;
    localparam int PIX_MAX = (1 << `CNN_O_BW) - 1;
    localparam int TIMEOUT = 100;            // cycles per wait

    logic      clk;
    logic      reset_n;
    logic      i_in_valid;
    fmap_t     i_in_fmap;
    wgt_all_t  i_weight;
    bias_all_t i_bias;
    logic      o_ot_valid;
    pix_out_t  o_ot_pix;

    pix_out_t exp_q[$];                      // expected pixels, oldest first
    longint   due_q[$];                      // cycle each one is due
    pix_out_t mon_exp;
    longint   mon_due;
    longint   cycle = 0;
    string    test_name = "reset";
    int       errors = 0;
    int       err_mark = 0;
    int       tests_run = 0;
    int       tests_failed = 0;

    tb_clock tb_clock_i (.clk(clk), .reset_n(reset_n));

    cnn_core cnn_core_i (
        .clk(clk), .reset_n(reset_n), .i_in_valid(i_in_valid), .i_in_fmap(i_in_fmap),
        .i_weight(i_weight), .i_bias(i_bias), .o_ot_valid(o_ot_valid), .o_ot_pix(o_ot_pix)
    );

    // ======================================================================
    // reference model and stimulus helpers
    // ======================================================================
    function automatic pix_out_t expected_pix(input fmap_t f, input wgt_all_t w,
                                              input bias_all_t b);
        pix_out_t p;
        int       acc;
        for (int o = 0; o < `CNN_CO; o++) begin
            acc = int'(b[o]);
            for (int c = 0; c < `CNN_CI; c++) begin
                for (int k = 0; k < N_TAP; k++) begin
                    acc += int'(f.win[c][k]) * int'(w[o][c][k]);
                end
            end
            if (acc < 0) p[o] = '0;                   // ReLU
            else if (acc > PIX_MAX) p[o] = '1;        // clip
            else p[o] = pix_t'(acc);
        end
        return p;
    endfunction

    function automatic fmap_t rand_fmap(input int lo, input int hi);
        fmap_t f;
        for (int c = 0; c < `CNN_CI; c++) begin
            for (int k = 0; k < N_TAP; k++) begin
                f.win[c][k] = fval_t'(lo + int'($urandom_range(0, hi - lo)));
            end
        end
        return f;
    endfunction

    // only called with the pipe empty, bias is read late in the lane
    task automatic load_params(input int w_lo, input int w_hi, input int b_lo,
                               input int b_hi);
        wgt_all_t  w;
        bias_all_t b;
        for (int o = 0; o < `CNN_CO; o++) begin
            b[o] = bias_t'(b_lo + int'($urandom_range(0, b_hi - b_lo)));
            for (int c = 0; c < `CNN_CI; c++) begin
                for (int k = 0; k < N_TAP; k++) begin
                    w[o][c][k] = wval_t'(w_lo + int'($urandom_range(0, w_hi - w_lo)));
                end
            end
        end
        @(posedge clk);
        i_in_valid <= 1'b0;
        i_weight   <= w;
        i_bias     <= b;
    endtask

    task automatic send_beat(input fmap_t f);
        @(posedge clk);
        i_in_valid <= 1'b1;
        i_in_fmap  <= f;
        exp_q.push_back(expected_pix(f, i_weight, i_bias));
        due_q.push_back(cycle + 5);          // accepted next edge, out 4 later
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        i_in_valid <= 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    // drain the pipe then report
    task automatic end_test();
        int t;
        idle_cycle();
        for (t = 0; t < TIMEOUT && exp_q.size() != 0; t++) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("timeout in %s: %0d outputs never arrived", test_name, exp_q.size());
            errors++;
            exp_q.delete();
            due_q.delete();
        end
        tests_run++;
        if (errors != err_mark) tests_failed++;
        $display("%-10s %s, %0d errors", test_name,
                 (errors == err_mark) ? "ok" : "failed", errors - err_mark);
    endtask

    // ======================================================================
    // output monitor
    // ======================================================================
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!reset_n) begin
            assert (!o_ot_valid) else begin
                $display("output valid during reset in %s", test_name);
                errors++;
            end
        end else if (o_ot_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("output in %s with no beat pending", test_name);
                errors++;
            end
            if (exp_q.size() != 0) begin
                mon_exp = exp_q.pop_front();
                mon_due = due_q.pop_front();
                assert (o_ot_pix == mon_exp) else begin
                    $display("Mismatch in %s: expected %h, actual %h",
                             test_name, mon_exp, o_ot_pix);
                    errors++;
                end
                assert (cycle == mon_due) else begin
                    $display("Mismatch in %s: expected output at cycle %0d, actual %0d",
                             test_name, mon_due, cycle);
                    errors++;
                end
            end
        end
    end

    // ======================================================================
    // tests
    // ======================================================================
    initial begin
        i_in_valid = 1'b0;
        i_in_fmap  = '0;
        i_weight   = '0;
        i_bias     = '0;
        void'($urandom(32'h15bc_674e));

        begin_test("reset");                 // monitor watches valid stay low
        for (int t = 0; t < TIMEOUT && !reset_n; t++) @(posedge clk);
        if (!reset_n) begin
            $display("timeout: reset never released");
            errors++;
        end
        repeat (8) idle_cycle();
        end_test();

        begin_test("single");
        load_params(-16, 15, -500, 500);
        for (int i = 0; i < 4; i++) begin
            send_beat(rand_fmap(-16, 15));
            repeat (6) idle_cycle();         // lone beats, pipe empty between
        end
        end_test();

        begin_test("stream");
        load_params(-128, 127, -32768, 32767);
        for (int i = 0; i < 20; i++) send_beat(rand_fmap(-128, 127));
        end_test();

        begin_test("negative");
        load_params(-8, -1, -200, -100);     // positive features, negative weights
        for (int i = 0; i < 3; i++) send_beat(rand_fmap(0, 15));
        end_test();

        begin_test("saturate");
        load_params(127, 127, 32767, 32767);
        for (int i = 0; i < 2; i++) send_beat(rand_fmap(127, 127));
        end_test();

        begin_test("gapped");
        load_params(-128, 127, -32768, 32767);
        for (int i = 0; i < 40; i++) begin
            if ($urandom_range(0, 1) == 1) send_beat(rand_fmap(-128, 127));
            else idle_cycle();
        end
        end_test();

        errors += cnn_core_i.cnn_core_chk_i.fail_cnt;
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== cnn_conv.f ====
+incdir+hw
hw/cnn_conv_pkg.sv
hw/cnn_kernel.sv
hw/cnn_acc_ci.sv
hw/cnn_bias_relu.sv
hw/cnn_core.sv
tests/tb_clock.sv
tests/cnn_core_chk.sv
tests/cnn_core_tb.sv

// ==== Makefile ====
# Verilator build and run for the cnn_conv convolution core
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= cnn_core_tb
FILELIST  ?= cnn_conv.f
BUILD     ?= build
LOG       ?= $(BUILD)/sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_FLAGS ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD LOG VFLAGS SIM_FLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) $(SIM_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD)
